// File: tlb_macros.svh
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// Address and page geometry
`define TLB_VA_WIDTH        32
`define TLB_PA_WIDTH        40
`define TLB_PAGE_BITS       12     // 4 kB pages

// Storage organisation
`define TLB_SETS            4
`define TLB_OFFSETS         4      // Entries per set in one bank
`define TLB_LANES           2      // Banks searched in parallel

// Configuration write port
`define TLB_CFG_DATA_WIDTH  64
`define TLB_CFG_ADDR_WIDTH  32

// Derived widths
`define TLB_SET_BITS        ($clog2(`TLB_SETS))
`define TLB_OFS_BITS        ($clog2(`TLB_OFFSETS))
`define TLB_LANE_BITS       ($clog2(`TLB_LANES))
`define TLB_VA_IDX_BITS     (`TLB_SET_BITS + `TLB_OFS_BITS)
`define TLB_PA_IDX_BITS     (`TLB_VA_IDX_BITS + `TLB_LANE_BITS)

`endif

// File: tlb_lookup_pkg.sv
`include "tlb_macros.svh"

package tlb_lookup_pkg;

   // Page numbers and the translated address
   typedef logic [`TLB_VA_WIDTH-`TLB_PAGE_BITS-1:0] vpn_t;
   typedef logic [`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0] ppn_t;
   typedef logic [`TLB_PA_WIDTH-1:0]                pa_addr_t;

   typedef logic [`TLB_VA_IDX_BITS-1:0] va_idx_t;   // Set above offset

   typedef enum logic {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEARCH,
      ST_DONE
   } search_state_e;

endpackage

// File: tlb_cfg_pkg.sv
`include "tlb_macros.svh"

package tlb_cfg_pkg;

   // Virtual tag entry with the page number in the low bits
   typedef struct packed {
      logic [`TLB_CFG_DATA_WIDTH-3-$bits(tlb_lookup_pkg::vpn_t)-1:0] pad;
      logic                 valid;
      logic                 rd_ok;    // Read access allowed
      logic                 wr_ok;    // Write access allowed
      tlb_lookup_pkg::vpn_t vpn;
   } va_entry_t;

   // Physical page entry
   typedef struct packed {
      logic [`TLB_CFG_DATA_WIDTH-$bits(tlb_lookup_pkg::ppn_t)-1:0] pad;
      tlb_lookup_pkg::ppn_t ppn;
   } pa_entry_t;

   // The same write data word is seen as a tag entry by the banks
   // and as a page entry by the physical RAM
   typedef union packed {
      va_entry_t va;
      pa_entry_t pa;
   } cfg_word_u;

endpackage

// File: tlb_cfg_if.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

interface tlb_cfg_if;
   import tlb_lookup_pkg::*;
   import tlb_cfg_pkg::*;

   logic [`TLB_LANES-1:0]       va_we;     // One enable per bank
   va_idx_t                     va_idx;
   logic                        pa_we;
   logic [`TLB_PA_IDX_BITS-1:0] pa_idx;    // Lane interleaved index
   cfg_word_u                   word;

   modport decode (
      output va_we, va_idx, pa_we, pa_idx, word
   );

   modport ram (
      input va_we, va_idx, pa_we, pa_idx, word
   );

endinterface

// File: tlb_cfg_decode.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tlb_cfg_decode (
   input  logic                           we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i,
   tlb_cfg_if.decode                      cfg
);
   import tlb_cfg_pkg::*;

   logic                      sel_pa;    // 1 targets the physical RAM
   logic [`TLB_LANE_BITS-1:0] lane;
   logic [`TLB_LANES-1:0]     va_we;

   // Write address from the top down is target bit, index, lane
   assign sel_pa = waddr_i[`TLB_VA_IDX_BITS + `TLB_LANE_BITS];
   assign lane   = waddr_i[`TLB_LANE_BITS-1:0];

   always_comb begin
      for (int l = 0; l < `TLB_LANES; l++) begin
         va_we[l] = we_i && !sel_pa && (lane == l[`TLB_LANE_BITS-1:0]);
      end
   end

   assign cfg.va_we  = va_we;
   assign cfg.va_idx = waddr_i[`TLB_LANE_BITS +: `TLB_VA_IDX_BITS];
   assign cfg.pa_we  = we_i && sel_pa;

   // Low bits already hold entry index times lanes plus lane
   assign cfg.pa_idx = waddr_i[`TLB_PA_IDX_BITS-1:0];
   assign cfg.word   = cfg_word_u'(wdata_i);

endmodule

// File: tlb_va_bank.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tlb_va_bank (
   input  logic                    clk_i,
   input  logic                    we_i,
   input  tlb_lookup_pkg::va_idx_t widx_i,
   input  tlb_cfg_pkg::va_entry_t  wentry_i,
   input  tlb_lookup_pkg::va_idx_t ridx_i,
   input  tlb_lookup_pkg::vpn_t    vpn_i,
   input  tlb_lookup_pkg::access_e access_i,
   output logic                    hit_o,
   output logic                    prot_o
);
   import tlb_lookup_pkg::*;
   import tlb_cfg_pkg::*;

   va_entry_t mem [`TLB_SETS*`TLB_OFFSETS];

   va_entry_t entry_q;    // Entry read last cycle
   vpn_t      vpn_q;
   access_e   access_q;
   logic      match;
   logic      allowed;

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[widx_i] <= wentry_i;
      end
   end

   // Page number and access kind stay aligned with the read data
   always_ff @(posedge clk_i) begin
      entry_q  <= mem[ridx_i];
      vpn_q    <= vpn_i;
      access_q <= access_i;
   end

   assign match   = entry_q.valid && (entry_q.vpn == vpn_q);
   assign allowed = (access_q == ACC_WRITE) ? entry_q.wr_ok : entry_q.rd_ok;

   assign hit_o  = match && allowed;
   assign prot_o = match && !allowed;   // Tag matches but access denied

endmodule

// File: tlb_search_ctrl.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tlb_search_ctrl (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        l1_miss_i,
   input  logic [`TLB_VA_WIDTH-1:0]    in_addr_i,
   input  tlb_lookup_pkg::access_e     rw_type_i,
   input  logic                        l2_trans_sent_i,
   input  logic [`TLB_LANES-1:0]       lane_hit_i,
   input  logic [`TLB_LANES-1:0]       lane_prot_i,
   output tlb_lookup_pkg::vpn_t        vpn_o,
   output tlb_lookup_pkg::access_e     access_o,
   output tlb_lookup_pkg::va_idx_t     ridx_o,
   output logic                        pa_rd_o,
   output logic [`TLB_PA_IDX_BITS-1:0] pa_idx_o,
   output logic [`TLB_PAGE_BITS-1:0]   page_ofs_o,
   output logic                        busy_o,
   output logic                        hit_o,
   output logic                        miss_o,
   output logic                        prot_o
);
   import tlb_lookup_pkg::*;

   search_state_e             state_q;
   search_state_e             state_d;
   logic                      accept;
   logic                      issue;        // Read index goes out this cycle
   logic                      stop;         // Search ends this cycle
   logic                      hold_q;       // Hit waits for the transfer

   vpn_t                      vpn_q;
   access_e                   access_q;
   logic [`TLB_SET_BITS-1:0]  set_q;
   logic [`TLB_PAGE_BITS-1:0] page_ofs_q;

   logic [`TLB_OFS_BITS-1:0]  ofs_q;
   logic                      cmp_vld_q;    // Bank compare valid this cycle
   logic [`TLB_OFS_BITS-1:0]  cmp_ofs_q;

   logic                      found;
   logic                      found_prot;
   logic [`TLB_LANE_BITS-1:0] found_lane;

   logic                      hit_q;
   logic                      miss_q;
   logic                      prot_q;

   ////////////////////////////////////////////////////////////////////////////
   // Lane priority

   always_comb begin
      found      = 1'b0;
      found_prot = 1'b0;
      found_lane = '0;
      for (int l = `TLB_LANES-1; l >= 0; l--) begin   // Lowest lane wins
         if (lane_hit_i[l] || lane_prot_i[l]) begin
            found      = 1'b1;
            found_prot = lane_prot_i[l];
            found_lane = l[`TLB_LANE_BITS-1:0];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Search FSM and offset sequencing

   assign accept = (state_q == ST_IDLE) && l1_miss_i;
   assign stop   = cmp_vld_q && (found || (int'(cmp_ofs_q) == `TLB_OFFSETS - 1));
   assign issue  = (state_q == ST_SEARCH) && !stop;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_d = ST_SEARCH;
            end
         end
         ST_SEARCH: begin
            if (stop) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            if (!hold_q || l2_trans_sent_i) begin   // Miss and fault leave at once
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q    <= ST_IDLE;
         ofs_q      <= '0;
         cmp_vld_q  <= 1'b0;
         hold_q     <= 1'b0;
         hit_q      <= 1'b0;
         miss_q     <= 1'b0;
         prot_q     <= 1'b0;
      end else begin
         state_q   <= state_d;
         cmp_vld_q <= issue;
         if (accept) begin
            ofs_q <= '0;
         end else if (issue) begin
            ofs_q <= ofs_q + 1'b1;
         end
         hit_q  <= stop && found && !found_prot;   // Lines up with PA RAM data
         prot_q <= stop && found && found_prot;
         miss_q <= stop && !found;
         if (stop) begin
            hold_q <= found && !found_prot;
         end
      end
   end

   // Request fields and the offset under compare
   always_ff @(posedge clk_i) begin
      cmp_ofs_q <= ofs_q;
      if (accept) begin
         vpn_q      <= in_addr_i[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
         access_q   <= rw_type_i;
         set_q      <= in_addr_i[`TLB_PAGE_BITS +: `TLB_SET_BITS];
         page_ofs_q <= in_addr_i[`TLB_PAGE_BITS-1:0];
      end
   end

   assign vpn_o      = vpn_q;
   assign access_o   = access_q;
   assign ridx_o     = {set_q, ofs_q};
   assign page_ofs_o = page_ofs_q;

   // Concatenation gives entry index times lane count plus lane
   assign pa_idx_o = {set_q, cmp_ofs_q, found_lane};
   assign pa_rd_o  = stop && found && !found_prot;

   assign busy_o = (state_q != ST_IDLE);
   assign hit_o  = hit_q;
   assign miss_o = miss_q;
   assign prot_o = prot_q;

endmodule

// File: tlb_pa_ram.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tlb_pa_ram (
   input  logic                        clk_i,
   tlb_cfg_if.ram                      cfg,
   input  logic                        rd_i,
   input  logic [`TLB_PA_IDX_BITS-1:0] ridx_i,
   input  logic [`TLB_PAGE_BITS-1:0]   page_ofs_i,
   output tlb_lookup_pkg::pa_addr_t    out_addr_o
);
   import tlb_lookup_pkg::*;

   // One row per entry index and lane
   ppn_t mem [`TLB_LANES*`TLB_SETS*`TLB_OFFSETS];
   ppn_t ppn_q;

   always_ff @(posedge clk_i) begin
      if (cfg.pa_we) begin
         mem[cfg.pa_idx] <= cfg.word.pa.ppn;
      end
   end

   // Held until the next hit reads a new page
   always_ff @(posedge clk_i) begin
      if (rd_i) begin
         ppn_q <= mem[ridx_i];
      end
   end

   assign out_addr_o = {ppn_q, page_ofs_i};   // Page offset passes untranslated

endmodule

// File: tlb_l2.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tlb_l2 (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic [`TLB_VA_WIDTH-1:0]       in_addr_i,
   input  logic                           rw_type_i,     // 1 write, 0 read
   input  logic                           l1_miss_i,
   input  logic                           we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i,
   input  logic                           l2_trans_sent_i,
   output logic                           hit_o,
   output logic                           miss_o,
   output logic                           prot_o,
   output logic                           busy_o,
   output logic [`TLB_PA_WIDTH-1:0]       out_addr_o
);
   import tlb_lookup_pkg::*;

   tlb_cfg_if cfg_bus ();

   vpn_t                        lookup_vpn;
   access_e                     lookup_access;
   va_idx_t                     ridx;
   logic [`TLB_LANES-1:0]       lane_hit;
   logic [`TLB_LANES-1:0]       lane_prot;
   logic                        pa_rd;
   logic [`TLB_PA_IDX_BITS-1:0] pa_idx;
   logic [`TLB_PAGE_BITS-1:0]   page_ofs;

   ////////////////////////////////////////////////////////////////////////////
   // Configuration writes

   tlb_cfg_decode u_decode (
      .we_i    (we_i),
      .waddr_i (waddr_i),
      .wdata_i (wdata_i),
      .cfg     (cfg_bus)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Tag banks that all read the same index

   for (genvar g = 0; g < `TLB_LANES; g++) begin : g_lane
      tlb_va_bank u_bank (
         .clk_i    (clk_i),
         .we_i     (cfg_bus.va_we[g]),
         .widx_i   (cfg_bus.va_idx),
         .wentry_i (cfg_bus.word.va),
         .ridx_i   (ridx),
         .vpn_i    (lookup_vpn),
         .access_i (lookup_access),
         .hit_o    (lane_hit[g]),
         .prot_o   (lane_prot[g])
      );
   end

   tlb_search_ctrl u_ctrl (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .l1_miss_i       (l1_miss_i),
      .in_addr_i       (in_addr_i),
      .rw_type_i       (access_e'(rw_type_i)),
      .l2_trans_sent_i (l2_trans_sent_i),
      .lane_hit_i      (lane_hit),
      .lane_prot_i     (lane_prot),
      .vpn_o           (lookup_vpn),
      .access_o        (lookup_access),
      .ridx_o          (ridx),
      .pa_rd_o         (pa_rd),
      .pa_idx_o        (pa_idx),
      .page_ofs_o      (page_ofs),
      .busy_o          (busy_o),
      .hit_o           (hit_o),
      .miss_o          (miss_o),
      .prot_o          (prot_o)
   );

   tlb_pa_ram u_pa_ram (
      .clk_i      (clk_i),
      .cfg        (cfg_bus),
      .rd_i       (pa_rd),
      .ridx_i     (pa_idx),
      .page_ofs_i (page_ofs),
      .out_addr_o (out_addr_o)
   );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS/2) clk_o = ~clk_o;
   end

   // Reset drops at the same point where stimulus is driven
   initial begin
      rst_no = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #10 rst_no = 1'b1;
   end

endmodule

// File: tb_tlb_l2.sv
`timescale 1ns/10ps
`include "tlb_macros.svh"

module tb_tlb_l2;
   import tlb_lookup_pkg::*;
   import tlb_cfg_pkg::*;

   localparam int RESULT_CYCLES   = `TLB_OFFSETS + 4;
   localparam int TEST_CYCLES     = `TLB_OFFSETS + 20;
   localparam int SETUP_CYCLES    = 8 + `TLB_LANES*`TLB_SETS*`TLB_OFFSETS;   // Reset and clearing
   localparam int WATCHDOG_CYCLES = SETUP_CYCLES + 5*TEST_CYCLES;

   logic                           clk;
   logic                           rst_n;
   logic [`TLB_VA_WIDTH-1:0]       in_addr;
   logic                           rw_type;
   logic                           l1_miss;
   logic                           we;
   logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr;
   logic [`TLB_CFG_DATA_WIDTH-1:0] wdata;
   logic                           l2_trans_sent;
   logic                           hit;
   logic                           miss;
   logic                           prot;
   logic                           busy;
   pa_addr_t                       out_addr;

   integer seed = 63;
   string  test_name;

   tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clk_gen0 (.clk_o(clk), .rst_no(rst_n));

   tlb_l2 dut0 (
      .clk_i           (clk),
      .rst_ni          (rst_n),
      .in_addr_i       (in_addr),
      .rw_type_i       (rw_type),
      .l1_miss_i       (l1_miss),
      .we_i            (we),
      .waddr_i         (waddr),
      .wdata_i         (wdata),
      .l2_trans_sent_i (l2_trans_sent),
      .hit_o           (hit),
      .miss_o          (miss),
      .prot_o          (prot),
      .busy_o          (busy),
      .out_addr_o      (out_addr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "Simulation stopped in %s", test_name);
   endtask

   task automatic check_flag(string what, logic exp, logic act);
      if (act !== exp) begin
         $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(string what, pa_addr_t exp, pa_addr_t act);
      if (act !== exp) begin
         $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic expect_pulses(logic exp_hit, logic exp_miss, logic exp_prot);
      check_flag("hit_o", exp_hit, hit);
      check_flag("miss_o", exp_miss, miss);
      check_flag("prot_o", exp_prot, prot);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   // Set number sits in VA bits 13:12 at the bottom of the page number
   function automatic int entry_index(vpn_t vpn, int ofs);
      return int'(vpn[`TLB_SET_BITS-1:0]) * `TLB_OFFSETS + ofs;
   endfunction

   function automatic pa_addr_t expected_pa(ppn_t ppn, logic [`TLB_VA_WIDTH-1:0] va);
      return {ppn, va[`TLB_PAGE_BITS-1:0]};   // Page offset untranslated
   endfunction

   task automatic cfg_write(logic [`TLB_CFG_ADDR_WIDTH-1:0] addr,
                            logic [`TLB_CFG_DATA_WIDTH-1:0] data);
      we    = 1'b1;
      waddr = addr;
      wdata = data;
      next_cycle();
      we    = 1'b0;
   endtask

   task automatic load_va_entry(int lane, int idx, logic valid, logic rd_ok, logic wr_ok,
                                vpn_t vpn);
      va_entry_t e;
      e       = '0;
      e.valid = valid;
      e.rd_ok = rd_ok;
      e.wr_ok = wr_ok;
      e.vpn   = vpn;
      cfg_write(32'((idx << `TLB_LANE_BITS) | lane), e);   // Target bit left at 0
   endtask

   task automatic load_pa_entry(int lane, int idx, ppn_t ppn);
      pa_entry_t e;
      e     = '0;
      e.ppn = ppn;
      cfg_write(32'((1 << `TLB_PA_IDX_BITS) | (idx*`TLB_LANES + lane)), e);
   endtask

   task automatic clear_entries();
      for (int idx = 0; idx < `TLB_SETS*`TLB_OFFSETS; idx++) begin
         for (int lane = 0; lane < `TLB_LANES; lane++) begin
            load_va_entry(lane, idx, 1'b0, 1'b0, 1'b0, '0);
         end
      end
   endtask

   task automatic start_lookup(logic [`TLB_VA_WIDTH-1:0] va, access_e acc);
      in_addr = va;
      rw_type = acc;
      l1_miss = 1'b1;
      next_cycle();
      l1_miss = 1'b0;
      check_flag("busy_o after accept", 1'b1, busy);
   endtask

   task automatic wait_result();
      int cycles;
      cycles = 0;
      while (hit !== 1'b1 && miss !== 1'b1 && prot !== 1'b1) begin
         if (cycles == RESULT_CYCLES) begin
            $display("No result pulse in %s within %0d cycles", test_name, RESULT_CYCLES);
            abort_run();
         end
         next_cycle();
         cycles++;
      end
   endtask

   task automatic release_hit();
      l2_trans_sent = 1'b1;
      next_cycle();
      l2_trans_sent = 1'b0;
      check_flag("busy_o after release", 1'b0, busy);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic empty_lookup_miss();
      vpn_t vpn;
      test_name = "empty_lookup_miss";
      vpn       = vpn_t'($random(seed));
      start_lookup({vpn, 12'h123}, ACC_READ);
      wait_result();
      expect_pulses(1'b0, 1'b1, 1'b0);
      next_cycle();
      expect_pulses(1'b0, 1'b0, 1'b0);
      check_flag("busy_o after miss", 1'b0, busy);
   endtask

   task automatic read_lookup_hit();
      vpn_t vpn;
      ppn_t ppn;
      int   idx;
      test_name = "read_lookup_hit";
      vpn       = vpn_t'($random(seed));
      ppn       = ppn_t'($random(seed));
      idx       = entry_index(vpn, 2);
      load_va_entry(1, idx, 1'b1, 1'b1, 1'b0, vpn);
      load_pa_entry(1, idx, ppn);
      start_lookup({vpn, 12'habc}, ACC_READ);
      wait_result();
      expect_pulses(1'b1, 1'b0, 1'b0);
      check_addr("out_addr_o", expected_pa(ppn, {vpn, 12'habc}), out_addr);
      next_cycle();
      expect_pulses(1'b0, 1'b0, 1'b0);
      check_flag("busy_o while held", 1'b1, busy);
      check_addr("out_addr_o held", expected_pa(ppn, {vpn, 12'habc}), out_addr);
      release_hit();
      load_va_entry(1, idx, 1'b0, 1'b0, 1'b0, vpn);
   endtask

   task automatic write_lookup_fault();
      vpn_t vpn;
      int   idx;
      test_name = "write_lookup_fault";
      vpn       = vpn_t'($random(seed));
      idx       = entry_index(vpn, 1);
      load_va_entry(0, idx, 1'b1, 1'b1, 1'b0, vpn);   // Read only page
      start_lookup({vpn, 12'h040}, ACC_WRITE);
      wait_result();
      expect_pulses(1'b0, 1'b0, 1'b1);
      next_cycle();
      check_flag("busy_o after fault", 1'b0, busy);
      load_va_entry(0, idx, 1'b0, 1'b0, 1'b0, vpn);
   endtask

   task automatic lowest_lane_wins();
      vpn_t vpn;
      ppn_t ppn0;
      ppn_t ppn1;
      int   idx;
      test_name = "lowest_lane_wins";
      vpn       = vpn_t'($random(seed));
      ppn0      = ppn_t'($random(seed));
      ppn1      = ~ppn0;
      idx       = entry_index(vpn, 3);
      load_va_entry(0, idx, 1'b1, 1'b1, 1'b1, vpn);
      load_va_entry(1, idx, 1'b1, 1'b1, 1'b1, vpn);
      load_pa_entry(0, idx, ppn0);
      load_pa_entry(1, idx, ppn1);
      start_lookup({vpn, 12'h7f8}, ACC_WRITE);
      wait_result();
      expect_pulses(1'b1, 1'b0, 1'b0);
      check_addr("out_addr_o", expected_pa(ppn0, {vpn, 12'h7f8}), out_addr);
      release_hit();
      load_va_entry(0, idx, 1'b0, 1'b0, 1'b0, vpn);
      load_va_entry(1, idx, 1'b0, 1'b0, 1'b0, vpn);
   endtask

   task automatic second_miss_ignored();
      vpn_t vpn_a;
      vpn_t vpn_b;
      ppn_t ppn_a;
      int   idx_a;
      int   idx_b;
      test_name = "second_miss_ignored";
      vpn_a     = vpn_t'($random(seed));
      vpn_b     = vpn_a + 1'b1;
      ppn_a     = ppn_t'($random(seed));
      idx_a     = entry_index(vpn_a, 2);
      idx_b     = entry_index(vpn_b, 0);
      load_va_entry(0, idx_a, 1'b1, 1'b1, 1'b1, vpn_a);
      load_pa_entry(0, idx_a, ppn_a);
      load_va_entry(0, idx_b, 1'b1, 1'b1, 1'b1, vpn_b);   // Would hit if accepted
      load_pa_entry(0, idx_b, ~ppn_a);
      start_lookup({vpn_a, 12'h111}, ACC_READ);
      in_addr = {vpn_b, 12'h999};
      l1_miss = 1'b1;
      next_cycle();
      l1_miss = 1'b0;
      expect_pulses(1'b0, 1'b0, 1'b0);
      wait_result();
      expect_pulses(1'b1, 1'b0, 1'b0);
      release_hit();
      check_addr("out_addr_o after release", expected_pa(ppn_a, {vpn_a, 12'h111}), out_addr);
      next_cycle();
      expect_pulses(1'b0, 1'b0, 1'b0);
      check_flag("busy_o stays low", 1'b0, busy);
      load_va_entry(0, idx_a, 1'b0, 1'b0, 1'b0, vpn_a);
      load_va_entry(0, idx_b, 1'b0, 1'b0, 1'b0, vpn_b);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      in_addr       = '0;
      rw_type       = 1'b0;
      l1_miss       = 1'b0;
      we            = 1'b0;
      waddr         = '0;
      wdata         = '0;
      l2_trans_sent = 1'b0;
      test_name     = "reset";
      wait (rst_n === 1'b1);
      expect_pulses(1'b0, 1'b0, 1'b0);
      check_flag("busy_o after reset", 1'b0, busy);
      clear_entries();
      empty_lookup_miss();
      read_lookup_hit();
      write_lookup_fault();
      lowest_lane_wins();
      second_miss_ignored();
      $display("TB PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      abort_run();
   end

endmodule

// File: verilog.f
+incdir+.
tlb_lookup_pkg.sv
tlb_cfg_pkg.sv
tlb_cfg_if.sv
tlb_cfg_decode.sv
tlb_va_bank.sv
tlb_search_ctrl.sv
tlb_pa_ram.sv
tlb_l2.sv
tb_clk_gen.sv
tb_tlb_l2.sv

// File: run.sh
#!/bin/sh
# Build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
   -f verilog.f --top-module tb_tlb_l2 -o tb_tlb_l2

./obj_dir/tb_tlb_l2
